/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_fetch_front -f fetch_front.f

run: compile
	@out="$$(./obj_dir/Vtb_fetch_front)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

/* fe_pkg.sv */
package fe_pkg;

    // address and instruction widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // rom size, indexed by pc[7:2]
    localparam int rom_depth = 64;
    localparam int rom_idx_w = $clog2(rom_depth);
    // byte window covered by the rom, pc wraps inside it
    localparam int pc_lo_w = rom_idx_w + 2;
    localparam logic [pc_lo_w-1:0] pc_step = 4;

    localparam logic [addr_w-1:0] reset_pc = '0;
    // addi x0,x0,0
    localparam logic [data_w-1:0] inst_nop = 32'h0000_0013;

    // free slots in the skid buffer
    localparam logic [1:0] skid_credits = 2'd2;

    // raw rv32i major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;

    typedef enum logic [1:0] {
        skid_empty,
        skid_busy,
        skid_full
    } skid_state_e;

    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_imm,
        op_reg,
        op_illegal
    } opcode_e;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [data_w-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        opcode_e           op;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [2:0]        funct3;
        logic [data_w-1:0] imm;
        logic [addr_w-1:0] target;
    } dec_inst_t;

endpackage

/* fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic i_redirect,
    input  logic i_out_fire,
    output logic o_issue,
    output logic o_rsp_valid
);

    // free skid slots not yet claimed by a fetch
    logic [1:0] credits;
    logic [1:0] credits_nxt;
    // holds off the first issue until reset is gone a cycle
    logic       run;
    logic       credit_ok;

    // a slot freed this cycle can be reused at once
    assign credit_ok = (credits != 2'd0) || i_out_fire;

    // no fetch while the pc is being redirected
    assign o_issue = run && credit_ok && !i_redirect;

    always_comb begin
        credits_nxt = credits;
        // issue claims a slot
        if (o_issue) begin
            credits_nxt = credits_nxt - 2'd1;
        end
        // output transfer frees one
        if (i_out_fire) begin
            credits_nxt = credits_nxt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run         <= 1'b0;
            credits     <= fe_pkg::skid_credits;
            o_rsp_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (i_redirect) begin
                // skid is flushed, all slots free again
                credits     <= fe_pkg::skid_credits;
                // kill the fetch in flight
                o_rsp_valid <= 1'b0;
            end else begin
                credits     <= credits_nxt;
                // rom data shows up one cycle after issue
                o_rsp_valid <= o_issue;
            end
        end
    end

endmodule

/* fetch_front.f */
fe_pkg.sv
pc_gen.sv
inst_rom.sv
fetch_ctrl.sv
fetch_id.sv
inst_decode.sv
fetch_front.sv
tb_fetch_front.sv

/* fetch_front.sv */
`timescale 1ns/1ps

module fetch_front (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_redirect,
    input  logic [fe_pkg::addr_w-1:0] i_redirect_pc,
    input  logic                      i_ready,
    output logic                      o_valid,
    output fe_pkg::dec_inst_t         o_dec
);

    logic                      issue;
    logic                      rsp_valid;
    logic                      out_fire;
    logic [fe_pkg::addr_w-1:0] pc;
    fe_pkg::fetch_pkt_t        rom_pkt;
    fe_pkg::fetch_pkt_t        id_pkt;

    // transfer at the decode port, returns a credit
    assign out_fire = o_valid && i_ready;

    // paces fetches against free skid slots
    fetch_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_redirect  (i_redirect),
        .i_out_fire  (out_fire),
        .o_issue     (issue),
        .o_rsp_valid (rsp_valid)
    );

    pc_gen u_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_issue       (issue),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_pc          (pc)
    );

    inst_rom u_rom (
        .clk     (clk),
        .i_issue (issue),
        .i_pc    (pc),
        .o_pkt   (rom_pkt)
    );

    // redirect also flushes the pipeline reg
    fetch_id u_fetch_id (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (rsp_valid),
        .i_pkt   (rom_pkt),
        .i_flush (i_redirect),
        .i_ready (i_ready),
        .o_valid (o_valid),
        .o_pkt   (id_pkt)
    );

    inst_decode u_decode (
        .i_pkt (id_pkt),
        .o_dec (o_dec)
    );

endmodule

/* fetch_id.sv */
`timescale 1ns/1ps

module fetch_id (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_valid,
    input  fe_pkg::fetch_pkt_t i_pkt,
    input  logic               i_flush,
    input  logic               i_ready,
    output logic               o_valid,
    output fe_pkg::fetch_pkt_t o_pkt
);

    fe_pkg::skid_state_e state;
    fe_pkg::skid_state_e state_nxt;

    // second slot, filled only while the output is stalled
    fe_pkg::fetch_pkt_t buf_pkt;

    logic insert;
    logic remove;
    logic load;
    logic flow;
    logic fill;
    logic flush_out;
    logic unload;
    logic out_wren;
    logic buf_wren;
    logic use_buf;

    // credits upstream keep a full buffer from seeing a packet
    assign insert = i_valid;
    assign remove = o_valid && i_ready;

    // empty buffer takes the packet into the output reg
    assign load      = (state == fe_pkg::skid_empty) && insert && !remove;
    // new packet replaces the one leaving
    assign flow      = (state == fe_pkg::skid_busy) && insert && remove;
    // output stalled, park new packet in the buffer reg
    assign fill      = (state == fe_pkg::skid_busy) && insert && !remove;
    // buffered packet moves up to the output
    assign flush_out = (state == fe_pkg::skid_full) && !insert && remove;
    // last packet leaves
    assign unload    = (state == fe_pkg::skid_busy) && !insert && remove;

    always_comb begin
        state_nxt = state;
        if (i_flush) begin
            // redirect drops everything held
            state_nxt = fe_pkg::skid_empty;
        end else if (load || flow || flush_out) begin
            state_nxt = fe_pkg::skid_busy;
        end else if (fill) begin
            state_nxt = fe_pkg::skid_full;
        end else if (unload) begin
            state_nxt = fe_pkg::skid_empty;
        end
    end

    assign out_wren = load || flow || flush_out;
    assign buf_wren = fill;
    assign use_buf  = flush_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= fe_pkg::skid_empty;
            o_valid <= 1'b0;
        end else begin
            state   <= state_nxt;
            // valid whenever the output reg holds a packet
            o_valid <= (state_nxt != fe_pkg::skid_empty);
        end
    end

    // output reg
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pkt.pc   <= fe_pkg::reset_pc;
            o_pkt.inst <= fe_pkg::inst_nop;
        end else if (out_wren) begin
            o_pkt <= use_buf ? buf_pkt : i_pkt;
        end
    end

    // buffer reg
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_pkt.pc   <= fe_pkg::reset_pc;
            buf_pkt.inst <= fe_pkg::inst_nop;
        end else if (buf_wren) begin
            buf_pkt <= i_pkt;
        end
    end

endmodule

/* inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  fe_pkg::fetch_pkt_t i_pkt,
    output fe_pkg::dec_inst_t  o_dec
);

    logic [fe_pkg::data_w-1:0] inst;
    logic [fe_pkg::data_w-1:0] imm;
    logic [fe_pkg::data_w-1:0] imm_i;
    logic [fe_pkg::data_w-1:0] imm_s;
    logic [fe_pkg::data_w-1:0] imm_b;
    logic [fe_pkg::data_w-1:0] imm_u;
    logic [fe_pkg::data_w-1:0] imm_j;
    fe_pkg::opcode_e           op;

    assign inst = i_pkt.inst;

    // sign extended immediates, one per format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    // b and j drop bit 0, always even
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // pick class and immediate from the major opcode
    always_comb begin
        case (inst[6:0])
            fe_pkg::opc_lui: begin
                op  = fe_pkg::op_lui;
                imm = imm_u;
            end
            fe_pkg::opc_auipc: begin
                op  = fe_pkg::op_auipc;
                imm = imm_u;
            end
            fe_pkg::opc_jal: begin
                op  = fe_pkg::op_jal;
                imm = imm_j;
            end
            fe_pkg::opc_jalr: begin
                op  = fe_pkg::op_jalr;
                imm = imm_i;
            end
            fe_pkg::opc_branch: begin
                op  = fe_pkg::op_branch;
                imm = imm_b;
            end
            fe_pkg::opc_load: begin
                op  = fe_pkg::op_load;
                imm = imm_i;
            end
            fe_pkg::opc_store: begin
                op  = fe_pkg::op_store;
                imm = imm_s;
            end
            fe_pkg::opc_imm: begin
                op  = fe_pkg::op_imm;
                imm = imm_i;
            end
            fe_pkg::opc_reg: begin
                // r-type has no immediate
                op  = fe_pkg::op_reg;
                imm = '0;
            end
            default: begin
                op  = fe_pkg::op_illegal;
                imm = '0;
            end
        endcase
    end

    // register fields taken raw, whatever the format
    assign o_dec.pc     = i_pkt.pc;
    assign o_dec.op     = op;
    assign o_dec.rd     = inst[11:7];
    assign o_dec.rs1    = inst[19:15];
    assign o_dec.rs2    = inst[24:20];
    assign o_dec.funct3 = inst[14:12];
    assign o_dec.imm    = imm;
    // branch/jump target, harmless for other classes
    assign o_dec.target = i_pkt.pc + imm;

endmodule

/* inst_rom.sv */
`timescale 1ns/1ps

module inst_rom (
    input  logic                      clk,
    input  logic                      i_issue,
    input  logic [fe_pkg::addr_w-1:0] i_pc,
    output fe_pkg::fetch_pkt_t        o_pkt
);

    logic [fe_pkg::data_w-1:0]    mem [fe_pkg::rom_depth];
    logic [fe_pkg::rom_idx_w-1:0] idx;

    // program image, two words per line
    initial begin
        $readmemh("prog.hex", mem);
    end

    // word index, byte offset dropped
    assign idx = i_pc[fe_pkg::pc_lo_w-1:2];

    // registered read, pc travels with its word
    always_ff @(posedge clk) begin
        if (i_issue) begin
            o_pkt.pc   <= i_pc;
            o_pkt.inst <= mem[idx];
        end
    end

endmodule

/* pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_issue,
    input  logic                      i_redirect,
    input  logic [fe_pkg::addr_w-1:0] i_redirect_pc,
    output logic [fe_pkg::addr_w-1:0] o_pc
);

    // low byte steps and wraps, upper bits stay put
    logic [fe_pkg::pc_lo_w-1:0] pc_lo_nxt;
    logic [fe_pkg::addr_w-1:0]  pc_seq;

    assign pc_lo_nxt = o_pc[fe_pkg::pc_lo_w-1:0] + fe_pkg::pc_step;
    assign pc_seq    = {o_pc[fe_pkg::addr_w-1:fe_pkg::pc_lo_w], pc_lo_nxt};

    // current pc is the rom address this cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= fe_pkg::reset_pc;
        end else if (i_redirect) begin
            // redirect beats a same-cycle issue
            o_pc <= i_redirect_pc;
        end else if (i_issue) begin
            o_pc <= pc_seq;
        end
    end

endmodule

/* prog.hex */
// two 32-bit instruction words per line, word 0 at pc 0
00000013 fff00093
12345137 800001b7
00001217 fffff297
0100036f ff9ff3ef
00008467 ffc104e7
00208463 fe209ee3
0040a503 ff812583
00a12223 fea12e23
00208633 402086b3
00000000 ffffffff
0000007f 0000000b
00000073 7ff00713
80000793 0017c813
7ffff8b7 fffff937
80000997 7fe00a6f
80000aef 7ff10b67
80010be7 7e000fe3
80000063 00f14c83
80012d03 7e112fa3
80012023 00c5f5b3
00d66633 0146d6b3
0000702b fe00007f
00a00593 01000613
00b60633 fff60613
fe061ee3 008000ef
00008067 00400a37
0000aa97 03200b13
016b2023 000b2b83
01740463 fe0b0ce3
3e800c13 c1800c93
019c0d33 0000000f
00000013 ff5ff06f

/* tb_fetch_front.sv */
`timescale 1ns/1ps

module tb_fetch_front;

    // run length sized for about 2000 transfers
    localparam int max_cycles = 4000;
    localparam int xfer_total = 2000;

    logic              clk;
    logic              rst_n;
    logic              i_redirect;
    logic [31:0]       i_redirect_pc;
    logic              i_ready;
    logic              o_valid;
    fe_pkg::dec_inst_t o_dec;

    // own copy of the program image
    logic [31:0]       prog [64];
    logic [31:0]       rng;
    logic [31:0]       exp_pc;
    logic              chain;
    logic              reset_seen;
    logic              hold_valid;
    fe_pkg::dec_inst_t hold_dec;
    logic [15:0]       op_seen;
    int                cycle_cnt;
    int                post_reset;
    int                xfer_cnt;
    int                redir_cnt;
    int                mismatches;
    int                other_errs;

    fetch_front i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_ready       (i_ready),
        .o_valid       (o_valid),
        .o_dec         (o_dec)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected decode of one word from the rv32i formats
    function automatic fe_pkg::dec_inst_t decode_ref(input logic [31:0] pc,
                                                     input logic [31:0] word);
        fe_pkg::dec_inst_t d;
        logic [31:0]       i_imm;
        logic [12:0]       b_off;
        logic [20:0]       j_off;
        i_imm    = $signed(word) >>> 20;
        b_off    = {word[31], word[7], word[30:25], word[11:8], 1'b0};
        j_off    = {word[31], word[19:12], word[20], word[30:21], 1'b0};
        d.pc     = pc;
        d.rd     = word[11:7];
        d.rs1    = word[19:15];
        d.rs2    = word[24:20];
        d.funct3 = word[14:12];
        case (word[6:0])
            7'h37:   d.op = fe_pkg::op_lui;
            7'h17:   d.op = fe_pkg::op_auipc;
            7'h6f:   d.op = fe_pkg::op_jal;
            7'h67:   d.op = fe_pkg::op_jalr;
            7'h63:   d.op = fe_pkg::op_branch;
            7'h03:   d.op = fe_pkg::op_load;
            7'h23:   d.op = fe_pkg::op_store;
            7'h13:   d.op = fe_pkg::op_imm;
            7'h33:   d.op = fe_pkg::op_reg;
            default: d.op = fe_pkg::op_illegal;
        endcase
        // immediate by format
        // r-type and illegal words carry none
        case (d.op)
            fe_pkg::op_lui, fe_pkg::op_auipc:  d.imm = {word[31:12], 12'h000};
            fe_pkg::op_jal:                    d.imm = $signed({j_off, 11'b0}) >>> 11;
            fe_pkg::op_branch:                 d.imm = $signed({b_off, 19'b0}) >>> 19;
            fe_pkg::op_store:                  d.imm = {i_imm[31:5], word[11:7]};
            fe_pkg::op_jalr, fe_pkg::op_load:  d.imm = i_imm;
            fe_pkg::op_imm:                    d.imm = i_imm;
            default:                           d.imm = 32'h0;
        endcase
        d.target = pc + d.imm;
        return d;
    endfunction

    task automatic finish_run();
        // every decode class must have been seen at the output
        assert (&op_seen[9:0]) else begin
            other_errs++;
            $display("not every opcode class reached the output, seen %b", op_seen[9:0]);
        end
        $display("errors %0d (mismatch %0d, other %0d), transfers %0d, redirects %0d",
                 mismatches + other_errs, mismatches, other_errs, xfer_cnt, redir_cnt);
        if (mismatches + other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // outputs compared at the rising edge
    always @(posedge clk) begin
        fe_pkg::dec_inst_t exp_dec;
        if (!rst_n) begin
            // first edge comes before the reset has taken hold
            if (reset_seen) begin
                assert (o_valid == 1'b0) else begin
                    other_errs++;
                    $display("o_valid high during reset at %0t", $time);
                end
            end
            reset_seen = 1'b1;
            post_reset = 0;
            exp_pc     = fe_pkg::reset_pc;
            hold_valid = 1'b0;
        end else begin
            // still quiet right after reset
            if (post_reset < 2) begin
                assert (o_valid == 1'b0) else begin
                    other_errs++;
                    $display("o_valid high right after reset at %0t", $time);
                end
                post_reset++;
            end
            // stalled output must hold still
            if (hold_valid) begin
                assert (o_valid && (o_dec == hold_dec)) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: output moved under stall, held pc %h, now %h",
                             $time, hold_dec.pc, o_dec.pc);
                end
            end
            if (o_valid && i_ready) begin
                exp_dec = decode_ref(exp_pc, prog[exp_pc[7:2]]);
                assert (o_dec == exp_dec) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: got/exp pc %h/%h op %0d/%0d imm %h/%h tgt %h/%h",
                             $time, o_dec.pc, exp_dec.pc, o_dec.op, exp_dec.op,
                             o_dec.imm, exp_dec.imm, o_dec.target, exp_dec.target);
                end
                op_seen[o_dec.op] = 1'b1;
                xfer_cnt++;
                // low byte wraps while upper bits stay
                exp_pc[7:0] = exp_pc[7:0] + 8'd4;
            end
            // transfer in the redirect cycle is still the old stream
            if (i_redirect) begin
                exp_pc = i_redirect_pc;
                redir_cnt++;
            end
            hold_valid = o_valid && !i_ready && !i_redirect;
            hold_dec   = o_dec;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            other_errs++;
            $display("timeout, run did not finish within %0d cycles", max_cycles);
            finish_run();
        end
    end

    // stimulus driven on the falling edge
    initial begin
        $readmemh("prog.hex", prog);
        clk           = 1'b0;
        rst_n         = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = 32'h0;
        i_ready       = 1'b0;
        rng           = 32'hc228563f;
        chain         = 1'b0;
        reset_seen    = 1'b0;
        hold_valid    = 1'b0;
        op_seen       = 16'h0;
        cycle_cnt     = 0;
        post_reset    = 0;
        xfer_cnt      = 0;
        redir_cnt     = 0;
        mismatches    = 0;
        other_errs    = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // straight run over several passes of the rom
        i_ready = 1'b1;
        while (xfer_cnt < 300) @(negedge clk);
        // back-pressure about half the time
        while (xfer_cnt < 900) begin
            @(negedge clk);
            rng     = xorshift(rng);
            i_ready = rng[0];
        end
        // random redirects and lighter back-pressure
        while (xfer_cnt < xfer_total) begin
            @(negedge clk);
            rng           = xorshift(rng);
            i_ready       = (rng[1:0] != 2'b00);
            i_redirect    = (rng[9:5] == 5'd0) || chain;
            i_redirect_pc = {16'h0, rng[31:24], rng[17:12], 2'b00};
            // sometimes a second redirect follows back to back
            chain         = i_redirect && (rng[21:20] == 2'b00);
        end
        finish_run();
    end

endmodule
